// ==== lockstep_divider.f ====
verilog/div_data_pkg.sv
verilog/div_status_pkg.sv
verilog/restoring_divider.sv
verilog/nonrestoring_divider.sv
verilog/lockstep_checker.sv
verilog/lockstep_divider.sv
sim/lockstep_divider_assertions.sv
sim/lockstep_divider_tb.sv

// ==== sim/lockstep_divider_tb.sv ====
`timescale 1ns/1ps

// directed tests for the lockstep divider against a behavioral division model
module lockstep_divider_tb;

	localparam int word_bits = div_data_pkg::data_width;
	localparam int latency = word_bits + 3;	// start edge to valid, 35 at 32 bits
	localparam int cycle_limit = 5000;	// roughly 70 divisions of 36 cycles plus margin

	logic clk;
	logic reset;
	logic start;
	div_data_pkg::div_request_t request;
	logic busy;
	logic valid;
	div_status_pkg::div_checked_t checked;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle_count = 0;
	int seed = 32'he0277786;	// fixed so every run sees the same operands

	lockstep_divider lockstep_divider_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.request(request),
		.busy(busy),
		.valid(valid),
		.checked(checked)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;	// 100 ns period
	end

	// hard stop in case a valid never shows up
	initial
	begin
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic compare
	(
		input string name,
		input logic [word_bits-1:0] actual,
		input logic [word_bits-1:0] expected
	);
		checks++;
		if (actual !== expected)
		begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// plain unsigned division, a zero divisor gives all ones and the dividend back
	function automatic div_data_pkg::div_result_t reference_result
	(
		input logic [word_bits-1:0] dividend,
		input logic [word_bits-1:0] divisor
	);
		div_data_pkg::div_result_t expect_r;
		if (divisor == '0)
		begin
			expect_r.quotient = '1;
			expect_r.remainder = dividend;
		end
		else
		begin
			expect_r.quotient = dividend / divisor;
			expect_r.remainder = dividend % divisor;
		end
		return expect_r;
	endfunction

	// every task starts and ends 1 ns after a rising edge
	task automatic launch_division
	(
		input logic [word_bits-1:0] dividend,
		input logic [word_bits-1:0] divisor,
		input logic fault
	);
		start = 1'b1;
		request.operands.dividend = dividend;
		request.operands.divisor = divisor;
		request.fault_inject = fault;
		@(posedge clk);
		#1;
		start = 1'b0;	// the DUT took the request on that edge
	endtask

	// elapsed is how many edges have already passed since the start edge
	task automatic await_and_check
	(
		input logic [word_bits-1:0] dividend,
		input logic [word_bits-1:0] divisor,
		input logic fault,
		input int elapsed
	);
		div_data_pkg::div_result_t expect_r;
		div_status_pkg::div_status_e expect_s;
		int cycles;
		expect_r = reference_result(dividend, divisor);
		if (fault)
			expect_s = div_status_pkg::status_mismatch;	// restoring result still expected
		else if (divisor == '0)
			expect_s = div_status_pkg::status_div_zero;
		else
			expect_s = div_status_pkg::status_ok;
		cycles = elapsed;
		while (!valid && cycles <= 2 * latency)
		begin
			compare("busy", busy, 1'b1);	// must stay up for the whole division
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!valid)
		begin
			$display("no valid strobe arrived within %0d cycles of start", 2 * latency);
			errors++;
		end
		else
		begin
			compare("latency", cycles, latency);
			compare("busy", busy, 1'b1);	// the valid cycle still counts as busy
			compare("checked.result.quotient", checked.result.quotient, expect_r.quotient);
			compare("checked.result.remainder", checked.result.remainder, expect_r.remainder);
			compare("checked.status", checked.status, expect_s);
		end
		@(posedge clk);
		#1;
		compare("valid", valid, 1'b0);
		compare("busy", busy, 1'b0);	// idle again, ready for the next start
	endtask

	task automatic do_divide
	(
		input logic [word_bits-1:0] dividend,
		input logic [word_bits-1:0] divisor,
		input logic fault
	);
		launch_division(dividend, divisor, fault);
		await_and_check(dividend, divisor, fault, 0);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("%-28s %s", name, (errors == errors_before) ? "passed" : "failed");
	endtask

	task automatic test_directed();
		int errors_before;
		errors_before = errors;
		do_divide(32'd100, 32'd7, 1'b0);
		do_divide(32'd7, 32'd100, 1'b0);	// quotient zero, remainder is the dividend
		do_divide(32'd12345, 32'd12345, 1'b0);
		do_divide(32'd0, 32'd9, 1'b0);
		do_divide(32'hdeadbeef, 32'd1, 1'b0);
		do_divide(32'hffffffff, 32'hffffffff, 1'b0);
		report_test("directed divisions", errors_before);
	endtask

	task automatic test_div_zero();
		int errors_before;
		errors_before = errors;
		do_divide(32'd0, 32'd0, 1'b0);
		do_divide(32'd1, 32'd0, 1'b0);
		do_divide(32'h12345678, 32'd0, 1'b0);
		do_divide(32'hffffffff, 32'd0, 1'b0);
		report_test("divide by zero", errors_before);
	endtask

	task automatic test_random();
		int errors_before;
		logic [word_bits-1:0] dividend;
		logic [word_bits-1:0] divisor;
		errors_before = errors;
		repeat (50)
		begin
			dividend = $random(seed);
			divisor = $random(seed);
			if ($random(seed) & 1)
				divisor[word_bits-1:word_bits/2] = '0;	// small divisors give big quotients
			do_divide(dividend, divisor, 1'b0);
		end
		report_test("random divisions", errors_before);
	endtask

	task automatic test_fault_inject();
		int errors_before;
		errors_before = errors;
		do_divide(32'd1000, 32'd33, 1'b1);
		do_divide(32'd1000, 32'd33, 1'b0);	// injection must not stick
		report_test("fault injection", errors_before);
	endtask

	task automatic test_start_while_busy();
		int errors_before;
		int stray;
		errors_before = errors;
		launch_division(32'd5000, 32'd3, 1'b0);
		@(posedge clk);
		#1;
		start = 1'b1;	// a zero divisor here would show up as div_zero if it leaked in
		request.operands.dividend = 32'd77;
		request.operands.divisor = 32'd0;
		@(posedge clk);
		#1;
		start = 1'b0;
		await_and_check(32'd5000, 32'd3, 1'b0, 2);
		stray = 0;
		repeat (latency + 5)
		begin
			if (valid)
				stray++;
			@(posedge clk);
			#1;
		end
		compare("extra valid strobes", stray, 0);
		report_test("start while busy", errors_before);
	endtask

	task automatic test_timing();
		int errors_before;
		errors_before = errors;
		compare("busy", busy, 1'b0);	// nothing running yet
		do_divide(32'h80000000, 32'd3, 1'b0);	// latency and busy are checked inside
		do_divide(32'd42, 32'd0, 1'b0);
		report_test("latency and busy", errors_before);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		request = '0;
		repeat (2)
			@(posedge clk);
		#1;
		reset = 1'b0;
		test_directed();
		test_div_zero();
		test_random();
		test_fault_inject();
		test_start_while_busy();
		test_timing();
		errors = errors + lockstep_divider_i.lockstep_divider_assertions_i.failures;
		$display("%0d tests, %0d checks, %0d errors including %0d assertion failures",
			tests, checks, errors, lockstep_divider_i.lockstep_divider_assertions_i.failures);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim/lockstep_divider_assertions.sv ====
`timescale 1ns/1ps

// handshake checks on the lockstep divider, bound to its top level
module lockstep_divider_assertions
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic valid
);

	localparam int latency = div_data_pkg::data_width + 3;	// start edge to valid edge

	int failures = 0;	// number of assertion failures so far

	// valid is a strobe and never lasts two cycles
	valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
		valid |=> !valid)
	else
	begin
		$error("valid was high in two consecutive cycles");
		failures++;
	end

	// valid rises on the edge one latency after the start edge
	// and is first seen high on the edge after that
	start_to_valid: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |=> ##latency valid)
	else
	begin
		$error("valid did not follow an accepted start after %0d cycles", latency);
		failures++;
	end

	// a start during the valid cycle is ignored, so busy must drop right after valid
	busy_drops_after_valid: assert property (@(posedge clk) disable iff (reset)
		valid |=> !busy)
	else
	begin
		$error("busy was still high in the cycle after valid");
		failures++;
	end

endmodule

bind lockstep_divider lockstep_divider_assertions lockstep_divider_assertions_i
(
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.valid(valid)
);

// ==== verilog/lockstep_divider.sv ====
`timescale 1ns/1ps

// lockstep unsigned divider, two serial units with different algorithms
// checked by a comparator, 35 cycles from start to valid at 32 bits
module lockstep_divider
(
	input logic clk,
	input logic reset,
	input logic start,	// one cycle strobe, ignored while busy
	input div_data_pkg::div_request_t request,	// sampled in the start cycle
	output logic busy,
	output logic valid,	// one cycle strobe, no back-pressure
	output div_status_pkg::div_checked_t checked
);

	logic start_accept;	// start that actually launches a division
	logic restoring_done;
	logic nonrestoring_done;
	div_data_pkg::div_result_t restoring_result;
	div_data_pkg::div_result_t nonrestoring_result;

	// requests arriving while a division runs are dropped, there is no queue
	assign start_accept = start && !busy;

	restoring_divider restoring_divider_i
	(
		.clk(clk),
		.reset(reset),
		.start(start_accept),
		.operands(request.operands),
		.done(restoring_done),
		.result(restoring_result)
	);

	// only this unit sees the fault bit, so an injected fault always shows as a mismatch
	nonrestoring_divider nonrestoring_divider_i
	(
		.clk(clk),
		.reset(reset),
		.start(start_accept),
		.operands(request.operands),
		.fault_inject(request.fault_inject),
		.done(nonrestoring_done),
		.result(nonrestoring_result)
	);

	lockstep_checker lockstep_checker_i
	(
		.clk(clk),
		.reset(reset),
		.start(start_accept),
		.operands(request.operands),	// for the zero divisor check
		.restoring_done(restoring_done),
		.restoring_result(restoring_result),
		.nonrestoring_done(nonrestoring_done),
		.nonrestoring_result(nonrestoring_result),
		.busy(busy),
		.valid(valid),
		.checked(checked)
	);

endmodule

// ==== verilog/lockstep_checker.sv ====
`timescale 1ns/1ps

// waits for both dividers, compares them and issues one checked result
// valid comes one cycle after the later of the two done strobes
module lockstep_checker
(
	input logic clk,
	input logic reset,
	input logic start,	// accepted start, already gated with busy upstream
	input div_data_pkg::div_operands_t operands,	// only the divisor is looked at
	input logic restoring_done,
	input div_data_pkg::div_result_t restoring_result,
	input logic nonrestoring_done,
	input div_data_pkg::div_result_t nonrestoring_result,
	output logic busy,	// from the cycle after start up to and including valid
	output logic valid,	// one cycle strobe
	output div_status_pkg::div_checked_t checked	// held until the next valid
);

	logic have_restoring;	// restoring result already collected
	logic have_nonrestoring;	// non-restoring result already collected
	logic div_zero_q;	// divisor of the running division was zero
	div_data_pkg::div_result_t restoring_held;
	div_data_pkg::div_result_t nonrestoring_held;
	div_data_pkg::div_result_t restoring_now;	// collected copy or the one arriving now
	div_data_pkg::div_result_t nonrestoring_now;
	logic both_in;	// both answers are available this cycle

	// a result counts as soon as its strobe is seen, no need to wait for the copy
	always_comb
	begin
		restoring_now = restoring_done ? restoring_result : restoring_held;
		nonrestoring_now = nonrestoring_done ? nonrestoring_result : nonrestoring_held;
		both_in = busy && (have_restoring || restoring_done)
			&& (have_nonrestoring || nonrestoring_done);
	end

	// busy, strobe and collected flags
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			valid <= 1'b0;
			have_restoring <= 1'b0;
			have_nonrestoring <= 1'b0;
		end
		else
		begin
			valid <= both_in;
			if (valid)
				busy <= 1'b0;	// the valid cycle itself still counts as busy
			else if (start)
				busy <= 1'b1;
			if (start || both_in)
			begin
				have_restoring <= 1'b0;	// ready for the next division
				have_nonrestoring <= 1'b0;
			end
			else
			begin
				if (restoring_done)
					have_restoring <= 1'b1;
				if (nonrestoring_done)
					have_nonrestoring <= 1'b1;
			end
		end
	end

	// captured results and the verdict
	always_ff @(posedge clk)
	begin
		if (start)
			div_zero_q <= (operands.divisor == '0);
		if (restoring_done)
			restoring_held <= restoring_result;
		if (nonrestoring_done)
			nonrestoring_held <= nonrestoring_result;
		if (both_in)
		begin
			checked.result <= restoring_now;	// on a mismatch the restoring unit is trusted
			if (restoring_now != nonrestoring_now)
				checked.status <= div_status_pkg::status_mismatch;
			else if (div_zero_q)
				checked.status <= div_status_pkg::status_div_zero;
			else
				checked.status <= div_status_pkg::status_ok;
		end
	end

endmodule

// ==== verilog/nonrestoring_divider.sv ====
`timescale 1ns/1ps

// serial non-restoring divider with a final remainder correction
// done rises data_width + 2 cycles after the start edge
module nonrestoring_divider
(
	input logic clk,
	input logic reset,
	input logic start,	// one cycle strobe, only honoured when idle
	input div_data_pkg::div_operands_t operands,	// sampled together with start
	input logic fault_inject,	// sampled with start, flips the quotient lsb on output
	output logic done,	// one cycle strobe
	output div_data_pkg::div_result_t result	// held from done until the next done
);

	localparam int word_bits = div_data_pkg::data_width;
	localparam int count_bits = $clog2(word_bits);

	// one extra state compared to the restoring unit for the correction step
	typedef enum logic [1:0]
	{
		st_idle,
		st_run,
		st_correct,
		st_finish
	} state_e;

	state_e state;
	logic [count_bits-1:0] count;	// iterations still left after the current one
	logic [word_bits:0] part_rem;	// two's complement partial remainder, msb is the sign
	logic [word_bits-1:0] quot;	// dividend shifts out at the top, quotient shifts in below
	logic [word_bits-1:0] divisor_q;	// divisor held for the whole division
	logic fault_q;	// injection request of the running division
	logic [word_bits+1:0] shifted;	// remainder doubled plus the next dividend bit
	logic [word_bits+1:0] stepped;	// after adding or subtracting the divisor

	// one iteration, the sign of the previous remainder picks add or subtract
	always_comb
	begin
		shifted = {part_rem, quot[word_bits-1]};
		if (part_rem[word_bits])
			stepped = shifted + {2'b00, divisor_q};	// negative so climb back up
		else
			stepped = shifted - {2'b00, divisor_q};
	end

	// control path
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
					begin
						state <= st_run;
						count <= count_bits'(word_bits - 1);
					end
				end
				st_run:
				begin
					count <= count - 1'b1;
					if (count == '0)
						state <= st_correct;
				end
				st_correct:
					state <= st_finish;	// remainder fixed up on this edge
				st_finish:
				begin
					state <= st_idle;
					done <= 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk)
	begin
		if (state == st_idle && start)
		begin
			part_rem <= '0;
			quot <= operands.dividend;
			divisor_q <= operands.divisor;
			fault_q <= fault_inject;
		end
		else if (state == st_run)
		begin
			// the new remainder lies in [-divisor, divisor) and fits one bit over a word
			part_rem <= stepped[word_bits:0];
			quot <= {quot[word_bits-2:0], ~stepped[word_bits]};	// non-negative gives a one
		end
		else if (state == st_correct && part_rem[word_bits])
			part_rem <= part_rem + {1'b0, divisor_q};	// last step overshot, add it back
		if (state == st_finish)
		begin
			// injection only touches the lsb so the remainder still agrees
			result.quotient <= quot ^ {{(word_bits-1){1'b0}}, fault_q};
			result.remainder <= part_rem[word_bits-1:0];
		end
	end

endmodule

// ==== verilog/restoring_divider.sv ====
`timescale 1ns/1ps

// serial restoring divider, one quotient bit per clock
// done rises data_width + 1 cycles after the start edge
module restoring_divider
(
	input logic clk,
	input logic reset,
	input logic start,	// one cycle strobe, only honoured when idle
	input div_data_pkg::div_operands_t operands,	// sampled together with start
	output logic done,	// one cycle strobe
	output div_data_pkg::div_result_t result	// held from done until the next done
);

	localparam int word_bits = div_data_pkg::data_width;
	localparam int count_bits = $clog2(word_bits);

	// run covers the data_width iterations, finish moves the answer to the output
	typedef enum logic [1:0]
	{
		st_idle,
		st_run,
		st_finish
	} state_e;

	state_e state;
	logic [count_bits-1:0] count;	// iterations still left after the current one
	logic [word_bits-1:0] part_rem;	// partial remainder, always below the divisor
	logic [word_bits-1:0] quot;	// dividend bits shift out at the top, quotient bits in at the bottom
	logic [word_bits-1:0] divisor_q;	// divisor copy kept for the whole division
	logic [word_bits+1:0] shifted;	// remainder shifted left with the next dividend bit
	logic [word_bits+1:0] diff;	// trial subtraction, two extra bits for the sign
	logic diff_neg;	// trial subtraction went below zero

	// trial subtraction of one iteration
	always_comb
	begin
		shifted = {1'b0, part_rem, quot[word_bits-1]};
		diff = shifted - {2'b00, divisor_q};
		diff_neg = diff[word_bits+1];	// borrow out means the divisor did not fit
	end

	// control path
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;	// strobe, so low by default
			case (state)
				st_idle:
				begin
					if (start)
					begin
						state <= st_run;
						count <= count_bits'(word_bits - 1);
					end
				end
				st_run:
				begin
					count <= count - 1'b1;
					if (count == '0)
						state <= st_finish;	// that was the lsb of the quotient
				end
				st_finish:
				begin
					state <= st_idle;
					done <= 1'b1;	// result register is written on this same edge
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk)
	begin
		if (state == st_idle && start)
		begin
			part_rem <= '0;
			quot <= operands.dividend;
			divisor_q <= operands.divisor;
		end
		else if (state == st_run)
		begin
			// on a negative difference the old remainder is kept, which is the restore
			if (diff_neg)
				part_rem <= shifted[word_bits-1:0];
			else
				part_rem <= diff[word_bits-1:0];
			quot <= {quot[word_bits-2:0], ~diff_neg};
		end
		// a zero divisor never borrows, so the quotient fills with ones and the
		// remainder collects the dividend bit by bit
		if (state == st_finish)
		begin
			result.quotient <= quot;
			result.remainder <= part_rem;
		end
	end

endmodule

// ==== verilog/div_status_pkg.sv ====
package div_status_pkg;

	// outcome of one lockstep comparison
	// the encoding is two bits wide so one code is left spare
	typedef enum logic [1:0]
	{
		status_ok = 2'd0,	// both units agree on a normal division
		status_div_zero = 2'd1,	// divisor was zero and both units still agree
		status_mismatch = 2'd2	// the units disagree, the restoring result is reported
	} div_status_e;

	// the single word the top level presents with each valid strobe
	// it stays put between two valid strobes
	typedef struct packed
	{
		div_data_pkg::div_result_t result;	// quotient and remainder
		div_status_e status;	// how far the result can be trusted
	} div_checked_t;

endpackage

// ==== verilog/div_data_pkg.sv ====
package div_data_pkg;

	// width of every operand and result word in the divider
	localparam int data_width = 32;

	// the two numbers of one division as they enter both units
	typedef struct packed
	{
		logic [data_width-1:0] dividend;	// numerator, unsigned
		logic [data_width-1:0] divisor;	// denominator, unsigned, zero is legal
	} div_operands_t;

	// one request as the outside hands it to the top level
	// fault_inject only reaches the non-restoring unit and flips its quotient lsb
	typedef struct packed
	{
		div_operands_t operands;	// forwarded unchanged to both dividers
		logic fault_inject;	// forces a mismatch when set
	} div_request_t;

	// what a single divider produces once it is done
	// for a zero divisor both units give all ones and the dividend back as remainder
	typedef struct packed
	{
		logic [data_width-1:0] quotient;	// floor of dividend over divisor
		logic [data_width-1:0] remainder;	// always smaller than a nonzero divisor
	} div_result_t;

	// packed layout, msb first
	// div_request_t is {dividend, divisor, fault_inject}, 2*data_width+1 bits
	// div_result_t is {quotient, remainder}, 2*data_width bits

endpackage
